/* files.f */
+incdir+verilog
verilog/stepper_pkg.sv
verilog/stepper_regs.sv
verilog/step_sequencer.sv
verilog/coil_chopper.sv
verilog/current_ref_pwm.sv
verilog/charge_pump.sv
verilog/stepper_top.sv
test/stepper_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal -f files.f --top-module stepper_tb -o stepper_sim
out=$(./obj_dir/stepper_sim)
echo "$out"
if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* test/stepper_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module stepper_tb;

  localparam int          TIMEOUT     = 1000;
  localparam int          NUM_CFG     = 6;
  localparam int          TBL_BASE    = 2 * NUM_CFG;
  localparam int          BURST_BASE  = TBL_BASE + 64;
  localparam logic [31:0] CTRL_ADDR   = 32'h000;
  localparam logic [31:0] SCALE_ADDR  = 32'h014;
  localparam logic [31:0] CP_ADDR     = 32'h018;
  localparam logic [31:0] STATUS_ADDR = 32'h01c;
  localparam logic [31:0] TABLE_ADDR  = 32'h100;
  localparam logic [1:0]  OKAY        = 2'b00;
  localparam logic [1:0]  SLVERR      = 2'b10;

  logic        clk;
  logic        resetn;
  logic        step;
  logic        dir;
  logic        cmp_a;
  logic        cmp_b;
  logic [31:0] s_awaddr;
  logic        s_awvalid;
  logic        s_awready;
  logic [31:0] s_wdata;
  logic [3:0]  s_wstrb;
  logic        s_wvalid;
  logic        s_wready;
  logic [1:0]  s_bresp;
  logic        s_bvalid;
  logic        s_bready;
  logic [31:0] s_araddr;
  logic        s_arvalid;
  logic        s_arready;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        s_rvalid;
  logic        s_rready;
  logic [3:0]  s_h;
  logic [3:0]  s_l;
  logic        ref_a;
  logic        ref_b;
  logic        chargepump_out;

  logic [31:0] vec [0:127];
  logic [7:0]  cos_tbl [0:63];
  logic [7:0]  scale;
  logic [7:0]  cp_period;
  logic [7:0]  model_pos;
  int          mismatches;
  int          failures;

  stepper_top stepper_top_i (.*);

  always #20 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    mismatches++;
  endtask

  task automatic note_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    failures++;
  endtask

  task automatic reset_dut;
    resetn = 1'b0;
    repeat (16) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int n;
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!s_awready && n < TIMEOUT);
    if (!s_awready) note_failure($sformatf("write to %h was never accepted", addr));
    if (s_wready !== 1'b1) report_mismatch("s_wready", {31'b0, s_wready}, 32'h1);
    @(negedge clk);  // handshake completes on this edge.
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    n = 0;
    while (!s_bvalid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!s_bvalid) note_failure($sformatf("no write response for %h", addr));
    if (s_bresp !== exp_resp) report_mismatch($sformatf("s_bresp at %h", addr), s_bresp, exp_resp);
    @(negedge clk);
    s_bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    int n;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!s_arready && n < TIMEOUT);
    if (!s_arready) note_failure($sformatf("read of %h was never accepted", addr));
    @(negedge clk);
    s_arvalid = 1'b0;
    n = 0;
    while (!s_rvalid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!s_rvalid) note_failure($sformatf("no read data for %h", addr));
    if (s_rresp !== exp_resp) report_mismatch($sformatf("s_rresp at %h", addr), s_rresp, exp_resp);
    if (s_rdata !== exp_data) report_mismatch($sformatf("s_rdata at %h", addr), s_rdata, exp_data);
    @(negedge clk);
    s_rready = 1'b0;
  endtask

  task automatic pulse_steps(input int count, input logic d);
    int i;
    dir = d;
    @(negedge clk);
    for (i = 0; i < count; i++) begin
      step = 1'b1;
      repeat (4) @(negedge clk);
      step = 1'b0;
      repeat (4) @(negedge clk);
    end
  endtask

  // mirrored index in odd quadrants for coil A and in even ones for coil B.
  function automatic logic [5:0] table_index(input logic [7:0] pos, input logic coil_b);
    logic odd;
    odd = (pos[7:6] == 2'd1) || (pos[7:6] == 2'd3);
    if (odd != coil_b) return 6'd63 - pos[5:0];
    return pos[5:0];
  endfunction

  function automatic logic [7:0] setpoint_of(input logic [7:0] pos, input logic coil_b);
    logic [15:0] prod;
    prod = 16'(cos_tbl[table_index(pos, coil_b)]) * 16'(scale);
    return prod[15:8];
  endfunction

  function automatic logic reversed(input logic [7:0] pos, input logic coil_b);
    if (coil_b) return pos[7:6] >= 2'd2;
    return (pos[7:6] == 2'd1) || (pos[7:6] == 2'd2);
  endfunction

  // high legs then low legs with leg 1 in bit 0.
  function automatic logic [3:0] drive_pattern(input logic rev);
    if (rev) return {2'b10, 2'b01};
    return {2'b01, 2'b10};
  endfunction

  task automatic check_gates(input logic inverted);
    logic [3:0] pa;
    logic [3:0] pb;
    logic [3:0] exp_h;
    logic [3:0] exp_l;
    pa = drive_pattern(reversed(model_pos, 1'b0));
    pb = drive_pattern(reversed(model_pos, 1'b1));
    exp_h = {pb[3:2], pa[3:2]} ^ {4{inverted}};
    exp_l = {pb[1:0], pa[1:0]} ^ {4{inverted}};
    if (s_h !== exp_h) report_mismatch("s_h", s_h, exp_h);
    if (s_l !== exp_l) report_mismatch("s_l", s_l, exp_l);
  endtask

  task automatic check_pwm;
    int high_a;
    int high_b;
    int i;
    high_a = 0;
    high_b = 0;
    for (i = 0; i < 256; i++) begin
      @(negedge clk);
      if (ref_a) high_a++;
      if (ref_b) high_b++;
    end
    if (high_a != int'(setpoint_of(model_pos, 1'b0)))
      report_mismatch("ref_a high count", high_a, setpoint_of(model_pos, 1'b0));
    if (high_b != int'(setpoint_of(model_pos, 1'b1)))
      report_mismatch("ref_b high count", high_b, setpoint_of(model_pos, 1'b1));
  endtask

  task automatic check_pump;
    logic last;
    int   gap;
    int   k;
    last = chargepump_out;
    gap = 0;
    while (chargepump_out === last && gap < TIMEOUT) begin
      @(negedge clk);
      gap++;
    end
    if (chargepump_out === last) note_failure("chargepump_out never toggled");
    for (k = 0; k < 4; k++) begin
      last = chargepump_out;
      gap = 0;
      do begin
        @(negedge clk);
        gap++;
      end while (chargepump_out === last && gap < TIMEOUT);
      if (gap != int'(cp_period) + 1)
        report_mismatch("chargepump_out toggle spacing", gap, int'(cp_period) + 1);
    end
  endtask

  // coil B has to hold its pattern the whole time.
  task automatic wait_coil_a(input logic [3:0] pat, input logic [3:0] pat_b,
                             input string what);
    int n;
    n = 0;
    while (!(s_h[1:0] === pat[3:2] && s_l[1:0] === pat[1:0]) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if ({s_h[3:2], s_l[3:2]} !== pat_b)
        report_mismatch("coil B gates", {s_h[3:2], s_l[3:2]}, pat_b);
    end
    if (!(s_h[1:0] === pat[3:2] && s_l[1:0] === pat[1:0]))
      note_failure({"coil A gates never showed ", what});
  endtask

  initial begin
    int         p;
    int         i;
    int         n;
    logic [3:0] pat_b;
    logic       rev_a;
    clk        = 1'b0;
    resetn     = 1'b0;
    step       = 1'b0;
    dir        = 1'b0;
    cmp_a      = 1'b0;
    cmp_b      = 1'b0;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wstrb    = 4'hf;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    mismatches = 0;
    failures   = 0;
    scale      = '0;
    cp_period  = '0;
    model_pos  = '0;
    $readmemh("test/stepper_vectors.txt", vec);
    for (i = 0; i < 64; i++) cos_tbl[i] = vec[TBL_BASE + i][7:0];
    reset_dut();

    for (i = 0; i < 64; i++) write_reg(TABLE_ADDR + 32'(4 * i), {24'b0, cos_tbl[i]}, OKAY);
    for (i = 0; i < 64; i++) read_reg(TABLE_ADDR + 32'(4 * i), {24'b0, cos_tbl[i]}, OKAY);
    for (i = 0; i < NUM_CFG; i++) begin
      write_reg(vec[2 * i], vec[2 * i + 1], OKAY);
      read_reg(vec[2 * i], vec[2 * i + 1], OKAY);
      if (vec[2 * i] == SCALE_ADDR) scale = vec[2 * i + 1][7:0];
      if (vec[2 * i] == CP_ADDR) cp_period = vec[2 * i + 1][7:0];
    end
    write_reg(32'h024, 32'h5a, SLVERR);
    read_reg(32'h020, 32'h0, SLVERR);
    read_reg(32'h200, 32'h0, SLVERR);
    check_pump();

    p = BURST_BASE;
    while (p < 124 && vec[p + 1] != 0) begin
      write_reg(CTRL_ADDR, {31'b0, vec[p][0]}, OKAY);
      pulse_steps(vec[p + 1], vec[p + 2][0]);
      if (vec[p][0]) model_pos = vec[p + 2][0] ? model_pos + vec[p + 1][7:0]
                                               : model_pos - vec[p + 1][7:0];
      if (vec[p + 3][7:0] !== model_pos)
        note_failure($sformatf("vector file expects position %h after burst at %0d",
                               vec[p + 3][7:0], p));
      read_reg(STATUS_ADDR, {24'b0, model_pos}, OKAY);
      if (vec[p][0]) check_gates(1'b0);
      check_pwm();
      p += 4;
    end

    write_reg(CTRL_ADDR, 32'h7, OKAY);
    read_reg(CTRL_ADDR, 32'h7, OKAY);
    check_gates(1'b1);
    write_reg(CTRL_ADDR, 32'h1, OKAY);

    // one trip on coil A well after the last polarity change.
    rev_a = reversed(model_pos, 1'b0);
    pat_b = drive_pattern(reversed(model_pos, 1'b1));
    cmp_a = 1'b1;
    @(negedge clk);
    cmp_a = 1'b0;
    wait_coil_a(drive_pattern(!rev_a), pat_b, "FAST decay");
    wait_coil_a({2'b00, 2'b11}, pat_b, "SLOW decay");
    wait_coil_a(drive_pattern(rev_a), pat_b, "DRIVE again");
    read_reg(STATUS_ADDR, {24'b0, model_pos}, OKAY);

    // step across a quadrant so coil A flips and trip inside minimum-on.
    dir = 1'b0;
    @(negedge clk);
    step = 1'b1;
    model_pos = model_pos - 8'd1;
    wait_coil_a(drive_pattern(reversed(model_pos, 1'b0)), pat_b, "the new polarity");
    cmp_a = 1'b1;
    @(negedge clk);
    cmp_a = 1'b0;
    step  = 1'b0;
    n = 0;
    while ((s_h !== 4'h0 || s_l !== 4'h0) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (s_h !== 4'h0 || s_l !== 4'h0) note_failure("gates stayed on after the fault");
    repeat (50) @(negedge clk);
    if (s_h !== 4'h0) report_mismatch("s_h", s_h, 4'h0);
    if (s_l !== 4'h0) report_mismatch("s_l", s_l, 4'h0);
    read_reg(STATUS_ADDR, {23'b0, 1'b1, model_pos}, OKAY);

    reset_dut();
    model_pos = '0;
    read_reg(STATUS_ADDR, 32'h0, OKAY);
    if (s_h !== 4'h0) report_mismatch("s_h", s_h, 4'h0);
    if (s_l !== 4'h0) report_mismatch("s_l", s_l, 4'h0);

    $display("%0d value errors, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(40 * 100000);
    $display("Simulation ran too long and was stopped at %0t ns", $time);
    $display("%0d value errors, %0d other failures", mismatches, failures + 1);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/stepper_vectors.txt */
// config writes, two words each: register offset, value.
// then 64 cosine table bytes, then bursts: enable, count, dir, expected position.
004 040
008 010
00c 030
010 008
014 0c0
018 005
// cosine table, index 0 first
ff ff ff fe fe fd fc fb
fa f9 f7 f6 f4 f2 f0 ee
ec e9 e7 e4 e1 de db d7
d4 d0 cd c9 c5 c1 bd b9
b4 b0 ab a7 a2 9d 98 93
8e 88 83 7e 78 73 6d 67
62 5c 56 50 4a 44 3e 38
32 2c 25 1f 19 13 0d 06
// step bursts, count 0 ends the list
0 05 1 00
1 03 0 fd
1 0a 1 07
1 40 1 47
1 40 1 87
1 47 0 40
0 00 0 00

/* verilog/charge_pump.sv */
`timescale 1ns/1ns
`default_nettype none

module charge_pump (
  input  wire       clk,
  input  wire       resetn,
  input  wire [7:0] period,
  output logic      pump
);

  logic [7:0] cnt;

  always_ff @(posedge clk) begin
    if (!resetn || period == '0) begin
      cnt  <= '0;
      pump <= 1'b0;  // parked low when unused.
    end else if (cnt == '0) begin
      cnt  <= period;
      pump <= ~pump;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/coil_chopper.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stepper_defines.svh"

module coil_chopper (
  input  wire                      clk,
  input  wire                      resetn,
  input  stepper_pkg::cfg_t        cfg,
  input  stepper_pkg::coil_cmd_t   cmd,
  input  wire                      cmp,
  output stepper_pkg::coil_drive_t drive,
  output logic                     fault_event
);

  logic [`STEPPER_TMR_W-1:0] blank_tmr;
  logic [`STEPPER_TMR_W-1:0] minon_tmr;
  logic [`STEPPER_OFF_W-1:0] off_tmr;
  logic [`STEPPER_OFF_W-1:0] off_next;
  stepper_pkg::decay_e       mode;
  stepper_pkg::decay_e       mode_next;
  logic                      trip;
  logic                      pol;

  // comparator only counts once blanking has run out.
  assign trip = cmp && (blank_tmr == '0);

  always_comb begin
    off_next = off_tmr;
    if (off_tmr != '0) begin
      off_next = off_tmr - 1'b1;
    end else if (trip) begin
      off_next = cfg.off_time;
    end
  end

  always_comb begin
    if (!cfg.enable) begin
      mode_next = stepper_pkg::OFF;
    end else if (off_next == '0) begin
      mode_next = stepper_pkg::DRIVE;
    end else if (off_next >= cfg.fastdecay_thr) begin
      mode_next = stepper_pkg::FAST;  // early part of off time.
    end else begin
      mode_next = stepper_pkg::SLOW;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_tmr <= '0;
      minon_tmr <= '0;
      off_tmr   <= '0;
      mode      <= stepper_pkg::OFF;
    end else begin
      off_tmr <= off_next;
      mode    <= mode_next;
      if (cmd.new_dir) begin
        blank_tmr <= cfg.blank_time;
        minon_tmr <= cfg.min_on_time;
      end else begin
        if (blank_tmr != '0) begin
          blank_tmr <= blank_tmr - 1'b1;
        end
        if (minon_tmr != '0) begin
          minon_tmr <= minon_tmr - 1'b1;
        end
      end
    end
  end

  // trip before minimum-on has elapsed means a shorted coil.
  assign fault_event = cmp && (minon_tmr != '0);

  // fast decay drives the opposite polarity.
  assign pol = cmd.reverse ^ (mode == stepper_pkg::FAST);

  always_comb begin
    drive = '0;
    case (mode)
      stepper_pkg::DRIVE, stepper_pkg::FAST: begin
        drive.high = pol ? 2'b10 : 2'b01;
        drive.low  = pol ? 2'b01 : 2'b10;
      end
      stepper_pkg::SLOW: begin
        drive.low = 2'b11;  // recirculate through low side.
      end
      default: begin
        drive = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/current_ref_pwm.sv */
`timescale 1ns/1ns
`default_nettype none

module current_ref_pwm (
  input  wire       clk,
  input  wire       resetn,
  input  wire [7:0] set_a,
  input  wire [7:0] set_b,
  output logic      ref_a,
  output logic      ref_b
);

  logic [7:0] cnt;
  logic [7:0] set_a_q;
  logic [7:0] set_b_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt     <= '0;
      set_a_q <= '0;
      set_b_q <= '0;
      ref_a   <= 1'b0;
      ref_b   <= 1'b0;
    end else begin
      cnt     <= cnt + 1'b1;  // wraps every 256.
      set_a_q <= set_a;
      set_b_q <= set_b;
      ref_a   <= cnt < set_a_q;
      ref_b   <= cnt < set_b_q;
    end
  end

endmodule

`default_nettype wire

/* verilog/step_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stepper_defines.svh"

module step_sequencer (
  input  wire                                   clk,
  input  wire                                   resetn,
  input  wire                                   step,
  input  wire                                   dir,
  input  stepper_pkg::cfg_t                     cfg,
  input  wire [7:0]                             cos_a,
  input  wire [7:0]                             cos_b,
  output logic [`STEPPER_POS_W-1:0]             position,
  output logic [$clog2(`STEPPER_COS_DEPTH)-1:0] idx_a,
  output logic [$clog2(`STEPPER_COS_DEPTH)-1:0] idx_b,
  output stepper_pkg::coil_cmd_t                cmd_a,
  output stepper_pkg::coil_cmd_t                cmd_b
);

  localparam int IDX_W = $clog2(`STEPPER_COS_DEPTH);

  logic [1:0]       step_sync;
  logic [1:0]       dir_sync;
  logic             step_d;
  logic             step_rise;
  logic [1:0]       quad;
  logic [IDX_W-1:0] offset;
  logic             rev_a;
  logic             rev_b;
  logic [15:0]      prod_a;
  logic [15:0]      prod_b;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_sync <= '0;
      dir_sync  <= '0;
      step_d    <= 1'b0;
      step_rise <= 1'b0;
    end else begin
      step_sync <= {step_sync[0], step};
      dir_sync  <= {dir_sync[0], dir};
      step_d    <= step_sync[1];
      step_rise <= step_sync[1] & ~step_d;  // registered edge.
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      position <= '0;
    end else if (step_rise && cfg.enable) begin
      position <= dir_sync[1] ? position + 1'b1 : position - 1'b1;
    end
  end

  assign quad   = position[`STEPPER_POS_W-1 -: 2];
  assign offset = position[IDX_W-1:0];

  // odd quadrants run the quarter wave backwards for coil a.
  assign idx_a = quad[0] ? ~offset : offset;
  assign idx_b = quad[0] ? offset : ~offset;
  assign rev_a = quad[1] ^ quad[0];  // quadrants 1 and 2.
  assign rev_b = quad[1];            // quadrants 2 and 3.

  assign prod_a = cos_a * cfg.cur_scale;
  assign prod_b = cos_b * cfg.cur_scale;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_a <= '0;
      cmd_b <= '0;
    end else begin
      cmd_a.setpoint <= prod_a[15:8];
      cmd_a.reverse  <= rev_a;
      cmd_a.new_dir  <= rev_a ^ cmd_a.reverse;
      cmd_b.setpoint <= prod_b[15:8];
      cmd_b.reverse  <= rev_b;
      cmd_b.new_dir  <= rev_b ^ cmd_b.reverse;
    end
  end

endmodule

`default_nettype wire

/* verilog/stepper_defines.svh */
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// electrical position width for 256 microsteps per cycle.
`define STEPPER_POS_W 8

// quarter-wave cosine table entries.
`define STEPPER_COS_DEPTH 64

// off timer width.
`define STEPPER_OFF_W 10

// blank and minimum-on timer width.
`define STEPPER_TMR_W 8

`endif

/* verilog/stepper_pkg.sv */
`default_nettype none

`include "stepper_defines.svh"

package stepper_pkg;

  typedef enum logic [8:0] {
    CTRL      = 9'h000,
    OFFTIME   = 9'h004,
    BLANKTIME = 9'h008,
    FASTDECAY = 9'h00C,
    MINON     = 9'h010,
    CUR_SCALE = 9'h014,
    CP_PERIOD = 9'h018,
    STATUS    = 9'h01C,
    COS_TABLE = 9'h100  // table runs to 0x1fc.
  } reg_addr_e;

  typedef enum logic [1:0] {
    DRIVE,
    FAST,
    SLOW,
    OFF
  } decay_e;

  typedef struct packed {
    logic                      enable;
    logic                      invert_high;
    logic                      invert_low;
    logic [`STEPPER_OFF_W-1:0] off_time;
    logic [`STEPPER_TMR_W-1:0] blank_time;
    logic [`STEPPER_OFF_W-1:0] fastdecay_thr;
    logic [`STEPPER_TMR_W-1:0] min_on_time;
    logic [7:0]                cur_scale;
    logic [7:0]                cp_period;
  } cfg_t;

  typedef struct packed {
    logic [1:0] high;
    logic [1:0] low;
  } coil_drive_t;

  typedef struct packed {
    logic       reverse;
    logic [7:0] setpoint;
    logic       new_dir;  // one cycle on polarity flip.
  } coil_cmd_t;

endpackage

`default_nettype wire

/* verilog/stepper_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stepper_defines.svh"

module stepper_regs (
  input  wire                                       clk,
  input  wire                                       resetn,
  input  wire [31:0]                                s_awaddr,
  input  wire                                       s_awvalid,
  output logic                                      s_awready,
  input  wire [31:0]                                s_wdata,
  input  wire [3:0]                                 s_wstrb,
  input  wire                                       s_wvalid,
  output logic                                      s_wready,
  output logic [1:0]                                s_bresp,
  output logic                                      s_bvalid,
  input  wire                                       s_bready,
  input  wire [31:0]                                s_araddr,
  input  wire                                       s_arvalid,
  output logic                                      s_arready,
  output logic [31:0]                               s_rdata,
  output logic [1:0]                                s_rresp,
  output logic                                      s_rvalid,
  input  wire                                       s_rready,
  input  wire [`STEPPER_POS_W-1:0]                  position,
  input  wire                                       fault,
  input  wire [$clog2(`STEPPER_COS_DEPTH)-1:0]      idx_a,
  input  wire [$clog2(`STEPPER_COS_DEPTH)-1:0]      idx_b,
  output stepper_pkg::cfg_t                         cfg,
  output logic [7:0]                                cos_a,
  output logic [7:0]                                cos_b
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_RESP} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_RESP} rd_state_e;

  wr_state_e              w_state;
  rd_state_e              r_state;
  stepper_pkg::reg_addr_e wr_reg;
  stepper_pkg::reg_addr_e rd_reg;
  logic                   wr_tbl;
  logic                   rd_tbl;
  logic [31:0]            rd_data;
  logic                   rd_err;
  logic [7:0]             cos_mem [`STEPPER_COS_DEPTH];

  assign wr_reg = stepper_pkg::reg_addr_e'(s_awaddr[8:0]);
  assign rd_reg = stepper_pkg::reg_addr_e'(s_araddr[8:0]);
  assign wr_tbl = (s_awaddr[31:9] == '0) && (s_awaddr[8:0] >= stepper_pkg::COS_TABLE);
  assign rd_tbl = (s_araddr[31:9] == '0) && (s_araddr[8:0] >= stepper_pkg::COS_TABLE);

  assign cos_a = cos_mem[idx_a];
  assign cos_b = cos_mem[idx_b];

  always_ff @(posedge clk) begin
    if (w_state == W_ACCEPT && wr_tbl) begin
      cos_mem[s_awaddr[7:2]] <= s_wdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      w_state   <= W_IDLE;
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      s_bvalid  <= 1'b0;
      s_bresp   <= RESP_OKAY;
      cfg       <= '0;
    end else begin
      case (w_state)
        W_IDLE: begin
          if (s_awvalid && s_wvalid) begin  // both channels together.
            s_awready <= 1'b1;
            s_wready  <= 1'b1;
            w_state   <= W_ACCEPT;
          end
        end
        W_ACCEPT: begin
          s_awready <= 1'b0;
          s_wready  <= 1'b0;
          s_bvalid  <= 1'b1;
          s_bresp   <= RESP_OKAY;
          w_state   <= W_RESP;
          if (s_awaddr[31:9] != '0) begin
            s_bresp <= RESP_SLVERR;
          end else if (!wr_tbl) begin
            case (wr_reg)
              stepper_pkg::CTRL: begin
                cfg.enable      <= s_wdata[0];
                cfg.invert_high <= s_wdata[1];
                cfg.invert_low  <= s_wdata[2];
              end
              stepper_pkg::OFFTIME:   cfg.off_time      <= s_wdata[`STEPPER_OFF_W-1:0];
              stepper_pkg::BLANKTIME: cfg.blank_time    <= s_wdata[`STEPPER_TMR_W-1:0];
              stepper_pkg::FASTDECAY: cfg.fastdecay_thr <= s_wdata[`STEPPER_OFF_W-1:0];
              stepper_pkg::MINON:     cfg.min_on_time   <= s_wdata[`STEPPER_TMR_W-1:0];
              stepper_pkg::CUR_SCALE: cfg.cur_scale     <= s_wdata[7:0];
              stepper_pkg::CP_PERIOD: cfg.cp_period     <= s_wdata[7:0];
              stepper_pkg::STATUS:    ;  // read only so the write is dropped.
              default:                s_bresp <= RESP_SLVERR;
            endcase
          end
        end
        W_RESP: begin
          if (s_bready) begin
            s_bvalid <= 1'b0;
            w_state  <= W_IDLE;
          end
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    if (s_araddr[31:9] != '0) begin
      rd_err = 1'b1;
    end else if (rd_tbl) begin
      rd_data = {24'b0, cos_mem[s_araddr[7:2]]};
    end else begin
      case (rd_reg)
        stepper_pkg::CTRL:      rd_data = {29'b0, cfg.invert_low, cfg.invert_high, cfg.enable};
        stepper_pkg::OFFTIME:   rd_data = {{(32-`STEPPER_OFF_W){1'b0}}, cfg.off_time};
        stepper_pkg::BLANKTIME: rd_data = {{(32-`STEPPER_TMR_W){1'b0}}, cfg.blank_time};
        stepper_pkg::FASTDECAY: rd_data = {{(32-`STEPPER_OFF_W){1'b0}}, cfg.fastdecay_thr};
        stepper_pkg::MINON:     rd_data = {{(32-`STEPPER_TMR_W){1'b0}}, cfg.min_on_time};
        stepper_pkg::CUR_SCALE: rd_data = {24'b0, cfg.cur_scale};
        stepper_pkg::CP_PERIOD: rd_data = {24'b0, cfg.cp_period};
        stepper_pkg::STATUS:    rd_data = {{(31-`STEPPER_POS_W){1'b0}}, fault, position};
        default:                rd_err  = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      r_state   <= R_IDLE;
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
      s_rresp   <= RESP_OKAY;
      s_rdata   <= '0;
    end else begin
      case (r_state)
        R_IDLE: begin
          if (s_arvalid) begin
            s_arready <= 1'b1;
            r_state   <= R_ACCEPT;
          end
        end
        R_ACCEPT: begin
          s_arready <= 1'b0;
          s_rvalid  <= 1'b1;
          s_rdata   <= rd_data;
          s_rresp   <= rd_err ? RESP_SLVERR : RESP_OKAY;
          r_state   <= R_RESP;
        end
        R_RESP: begin
          if (s_rready) begin
            s_rvalid <= 1'b0;
            r_state  <= R_IDLE;
          end
        end
        default: r_state <= R_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/stepper_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stepper_defines.svh"

module stepper_top (
  input  wire        clk,
  input  wire        resetn,
  input  wire        step,
  input  wire        dir,
  input  wire        cmp_a,
  input  wire        cmp_b,
  input  wire [31:0] s_awaddr,
  input  wire        s_awvalid,
  output logic       s_awready,
  input  wire [31:0] s_wdata,
  input  wire [3:0]  s_wstrb,
  input  wire        s_wvalid,
  output logic       s_wready,
  output logic [1:0] s_bresp,
  output logic       s_bvalid,
  input  wire        s_bready,
  input  wire [31:0] s_araddr,
  input  wire        s_arvalid,
  output logic       s_arready,
  output logic [31:0] s_rdata,
  output logic [1:0] s_rresp,
  output logic       s_rvalid,
  input  wire        s_rready,
  output logic [3:0] s_h,
  output logic [3:0] s_l,
  output logic       ref_a,
  output logic       ref_b,
  output logic       chargepump_out
);

  stepper_pkg::cfg_t                          cfg;
  stepper_pkg::coil_cmd_t                     cmd_a;
  stepper_pkg::coil_cmd_t                     cmd_b;
  stepper_pkg::coil_drive_t                   drive_a;
  stepper_pkg::coil_drive_t                   drive_b;
  stepper_pkg::coil_drive_t [1:0]             gate;  // index 0 is coil a.
  logic [`STEPPER_POS_W-1:0]                  position;
  logic [$clog2(`STEPPER_COS_DEPTH)-1:0]      idx_a;
  logic [$clog2(`STEPPER_COS_DEPTH)-1:0]      idx_b;
  logic [7:0]                                 cos_a;
  logic [7:0]                                 cos_b;
  logic                                       fault_ev_a;
  logic                                       fault_ev_b;
  logic                                       fault_q;

  stepper_regs regs_i (
    .clk(clk), .resetn(resetn),
    .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .position(position), .fault(fault_q), .idx_a(idx_a), .idx_b(idx_b),
    .cfg(cfg), .cos_a(cos_a), .cos_b(cos_b)
  );

  step_sequencer seq_i (
    .clk(clk), .resetn(resetn), .step(step), .dir(dir), .cfg(cfg),
    .cos_a(cos_a), .cos_b(cos_b), .position(position),
    .idx_a(idx_a), .idx_b(idx_b), .cmd_a(cmd_a), .cmd_b(cmd_b)
  );

  coil_chopper chop_a (
    .clk(clk), .resetn(resetn), .cfg(cfg), .cmd(cmd_a), .cmp(cmp_a),
    .drive(drive_a), .fault_event(fault_ev_a)
  );

  coil_chopper chop_b (
    .clk(clk), .resetn(resetn), .cfg(cfg), .cmd(cmd_b), .cmp(cmp_b),
    .drive(drive_b), .fault_event(fault_ev_b)
  );

  current_ref_pwm pwm_i (
    .clk(clk), .resetn(resetn), .set_a(cmd_a.setpoint), .set_b(cmd_b.setpoint),
    .ref_a(ref_a), .ref_b(ref_b)
  );

  charge_pump cp_i (
    .clk(clk), .resetn(resetn), .period(cfg.cp_period), .pump(chargepump_out)
  );

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fault_q <= 1'b0;
    end else if (fault_ev_a || fault_ev_b) begin
      fault_q <= 1'b1;  // sticky until reset.
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || fault_q || !cfg.enable) begin
      gate <= '0;
    end else begin
      gate <= {drive_b, drive_a};
    end
  end

  assign s_h = {gate[1].high, gate[0].high} ^ {4{cfg.invert_high}};
  assign s_l = {gate[1].low, gate[0].low} ^ {4{cfg.invert_low}};

endmodule

`default_nettype wire
